/* Makefile */
SIM        = verilator
FLAGS      = --binary --timing --timescale 1ns/1ps -j 0
LINT_FLAGS = --lint-only --timing --timescale 1ns/1ps
TOP        = agen_tb
FLIST      = flist.f
BUILD_DIR  = obj_dir
PASS_MSG   = Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

# Fails unless the pass message shows up in the simulation output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR)

/* flist.f */
+incdir+include
source/agen_pkg.sv
source/agen_control.sv
source/ea_unit.sv
source/flow_unit.sv
source/dep_check.sv
source/scoreboard_gen.sv
source/agen_stage.sv
test/agen_checker.sv
test/agen_tb.sv

/* include/agen_cfg.svh */
`ifndef AGEN_CFG_SVH
`define AGEN_CFG_SVH

// Interrupt descriptor table entry addresses at eight bytes per gate
`define AGEN_NMI_VECTOR 32'h0000_0010
`define AGEN_PF_VECTOR  32'h0000_0070
`define AGEN_GP_VECTOR  32'h0000_0068

// Width of the SIB scale field for an index shift of up to 3
`define AGEN_SCALE_W 2

// Stack pointer decrement per push by operand size
`define AGEN_PUSH_STEP_16 32'd2
`define AGEN_PUSH_STEP_32 32'd4
`define AGEN_PUSH_STEP_64 32'd8

`endif

/* source/agen_control.sv */
`timescale 1ns/1ps

module agen_control (
   input  logic               clk,
   input  logic               rst,
   input  agen_pkg::op_kind_t kind,
   input  logic               in_valid,
   input  logic               hazard,
   input  logic               hold,
   output agen_pkg::ag_ctrl_t ctrl,
   output logic               stall,
   output logic               load_en,
   output logic               out_valid
);
   import agen_pkg::*;

   logic accept;

   // Datapath selects per op kind
   always_comb begin
      ctrl = '0;
      case (kind)
         OP_PUSH: begin
            // ESP comes in on sr2 and is written back, SS is seg2
            ctrl.sp_push   = 1'b1;
            ctrl.use_sr2   = 1'b1;
            ctrl.need_seg2 = 1'b1;
            ctrl.ld_gpr2   = 1'b1;
         end
         OP_JMP_REL: begin
            ctrl.rel_jmp = 1'b1;
         end
         OP_JMP_FAR: begin
            ctrl.far_jmp = 1'b1;
         end
         OP_LOAD_SEG: begin
            ctrl.ld_seg = 1'b1;
         end
         // ALU, plain loads and stores, INT need no extra selects
         default: begin
            ctrl = '0;
         end
      endcase
   end

   // Hold from downstream always blocks decode
   assign stall   = hold | (in_valid & hazard);
   assign accept  = in_valid & ~stall;
   assign load_en = accept;

   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid <= 1'b0;
      end else if (!hold) begin
         out_valid <= accept;
      end
   end

endmodule

/* source/agen_pkg.sv */
`include "agen_cfg.svh"

package agen_pkg;

   typedef logic [31:0] addr_t;
   typedef logic [15:0] sel_t;
   typedef logic [2:0]  reg_id_t;
   typedef logic [7:0]  sb_t;

   // 1 = 16-bit, 2 = 32-bit, 3 = 64-bit
   typedef logic [1:0]  mem_size_t;

   typedef enum logic [2:0] {
      OP_ALU,
      OP_LOAD,
      OP_STORE,
      OP_PUSH,
      OP_JMP_REL,
      OP_JMP_FAR,
      OP_LOAD_SEG,
      OP_INT
   } op_kind_t;

   // Decoded micro-op as handed over by decode
   typedef struct packed {
      op_kind_t                  kind;
      addr_t                     eip;
      sel_t                      cs;
      logic [47:0]               offset;     // selector:offset for far jumps
      reg_id_t                   sr1;
      reg_id_t                   sr2;
      reg_id_t                   sib_i;
      reg_id_t                   seg1;
      reg_id_t                   seg2;
      logic                      sib_en;
      logic                      disp_en;
      logic                      base_en;
      logic [`AGEN_SCALE_W-1:0]  scale;
      logic                      seg_is_cs;
      addr_t                     disp;
      addr_t                     sr1_data;
      addr_t                     sr2_data;
      addr_t                     sib_i_data;
      sel_t                      seg1_data;
      mem_size_t                 mem_size;
      reg_id_t                   dr1;
      logic                      ld_gpr1;
   } agen_in_t;

   // Pending writes of one later stage
   typedef struct packed {
      logic valid;
      sb_t  gpr;
      sb_t  seg;
      sb_t  mm;
   } stage_sb_t;

   typedef struct packed {
      logic rel_jmp;
      logic far_jmp;
      logic sp_push;
      logic use_sr2;
      logic need_seg2;
      logic ld_seg;
      logic ld_gpr2;
   } ag_ctrl_t;

   typedef struct packed {
      addr_t lin_addr;
      addr_t neip;
      sel_t  ncs;
      addr_t sp_new;
      addr_t int_addr;
      sb_t   gpr_sb;
      sb_t   seg_sb;
      sb_t   mm_sb;
   } agen_out_t;

   // One-hot scoreboard bit for a register number
   function automatic sb_t reg_bit(input reg_id_t id);
      return sb_t'(1) << id;
   endfunction

endpackage

/* source/agen_stage.sv */
`timescale 1ns/1ps

module agen_stage (
   input  logic                clk,
   input  logic                rst,
   input  agen_pkg::agen_in_t  in,
   input  logic                in_valid,
   output logic                stall,
   input  agen_pkg::stage_sb_t ag2_sb,
   input  agen_pkg::stage_sb_t me_sb,
   input  agen_pkg::stage_sb_t me2_sb,
   input  agen_pkg::stage_sb_t ex_sb,
   input  logic                nmi_en,
   input  logic                pf_en,
   input  logic                gp_en,
   input  logic                hold,
   output agen_pkg::agen_out_t out,
   output logic                out_valid
);
   import agen_pkg::*;

   ag_ctrl_t  ctrl;
   logic      hazard;
   logic      load_en;
   addr_t     lin_addr;
   addr_t     neip;
   sel_t      ncs;
   addr_t     sp_new;
   addr_t     int_addr;
   sb_t       gpr_sb;
   sb_t       seg_sb;
   sb_t       mm_sb;
   agen_out_t result;

   agen_control u_control (
      .clk       (clk),
      .rst       (rst),
      .kind      (in.kind),
      .in_valid  (in_valid),
      .hazard    (hazard),
      .hold      (hold),
      .ctrl      (ctrl),
      .stall     (stall),
      .load_en   (load_en),
      .out_valid (out_valid)
   );

   ea_unit u_ea (
      .op       (in),
      .lin_addr (lin_addr)
   );

   flow_unit u_flow (
      .op       (in),
      .ctrl     (ctrl),
      .nmi_en   (nmi_en),
      .pf_en    (pf_en),
      .gp_en    (gp_en),
      .neip     (neip),
      .ncs      (ncs),
      .sp_new   (sp_new),
      .int_addr (int_addr)
   );

   dep_check u_dep (
      .op     (in),
      .ctrl   (ctrl),
      .ag2_sb (ag2_sb),
      .me_sb  (me_sb),
      .me2_sb (me2_sb),
      .ex_sb  (ex_sb),
      .hazard (hazard)
   );

   // dr2 is the stack pointer register carried on sr2
   scoreboard_gen u_sb (
      .dr1     (in.dr1),
      .dr2     (in.sr2),
      .ld_gpr1 (in.ld_gpr1),
      .ctrl    (ctrl),
      .gpr_sb  (gpr_sb),
      .seg_sb  (seg_sb),
      .mm_sb   (mm_sb)
   );

   always_comb begin
      result.lin_addr = lin_addr;
      result.neip     = neip;
      result.ncs      = ncs;
      result.sp_new   = sp_new;
      result.int_addr = int_addr;
      result.gpr_sb   = gpr_sb;
      result.seg_sb   = seg_sb;
      result.mm_sb    = mm_sb;
   end

   // Pipeline register toward the second address stage
   always_ff @(posedge clk) begin
      if (rst) begin
         out <= '0;
      end else if (load_en) begin
         out <= result;
      end
   end

endmodule

/* source/dep_check.sv */
`timescale 1ns/1ps

module dep_check (
   input  agen_pkg::agen_in_t  op,
   input  agen_pkg::ag_ctrl_t  ctrl,
   input  agen_pkg::stage_sb_t ag2_sb,
   input  agen_pkg::stage_sb_t me_sb,
   input  agen_pkg::stage_sb_t me2_sb,
   input  agen_pkg::stage_sb_t ex_sb,
   output logic                hazard
);
   import agen_pkg::*;

   logic mem_op;
   sb_t  gpr_need;
   sb_t  seg_need;
   logic hit_ag2;
   logic hit_me;
   logic hit_me2;
   logic hit_ex;

   // Ops that form a memory address through seg1
   always_comb begin
      case (op.kind)
         OP_LOAD, OP_STORE, OP_LOAD_SEG: mem_op = 1'b1;
         default:                        mem_op = 1'b0;
      endcase
   end

   always_comb begin
      gpr_need = '0;
      seg_need = '0;
      if (op.base_en) begin
         gpr_need |= reg_bit(op.sr1);
      end
      if (op.sib_en) begin
         gpr_need |= reg_bit(op.sib_i);
      end
      if (ctrl.use_sr2) begin
         gpr_need |= reg_bit(op.sr2);
      end
      // CS is never renamed here, so only a real seg1 counts
      if (mem_op && !op.seg_is_cs) begin
         seg_need |= reg_bit(op.seg1);
      end
      if (ctrl.need_seg2) begin
         seg_need |= reg_bit(op.seg2);
      end
   end

   assign hit_ag2 = ag2_sb.valid & (|(gpr_need & ag2_sb.gpr) | |(seg_need & ag2_sb.seg));
   assign hit_me  = me_sb.valid  & (|(gpr_need & me_sb.gpr)  | |(seg_need & me_sb.seg));
   assign hit_me2 = me2_sb.valid & (|(gpr_need & me2_sb.gpr) | |(seg_need & me2_sb.seg));
   assign hit_ex  = ex_sb.valid  & (|(gpr_need & ex_sb.gpr)  | |(seg_need & ex_sb.seg));

   assign hazard = hit_ag2 | hit_me | hit_me2 | hit_ex;

endmodule

/* source/ea_unit.sv */
`timescale 1ns/1ps

module ea_unit (
   input  agen_pkg::agen_in_t op,
   output agen_pkg::addr_t    lin_addr
);
   import agen_pkg::*;

   addr_t base_term;
   addr_t disp_term;
   addr_t index_term;
   sel_t  seg_sel;
   addr_t seg_term;
   addr_t eff_addr;

   // Each term drops to zero when its enable is clear
   always_comb begin
      base_term  = '0;
      disp_term  = '0;
      index_term = '0;
      if (op.base_en) begin
         base_term = op.sr1_data;
      end
      if (op.disp_en) begin
         disp_term = op.disp;
      end
      if (op.sib_en) begin
         index_term = op.sib_i_data << op.scale;
      end
   end

   assign eff_addr = base_term + disp_term + index_term;

   // Real-mode style segment base with the selector moved up by 16 bits
   assign seg_sel  = op.seg_is_cs ? op.cs : op.seg1_data;
   assign seg_term = {seg_sel, 16'h0000};

   assign lin_addr = eff_addr + seg_term;

endmodule

/* source/flow_unit.sv */
`timescale 1ns/1ps

`include "agen_cfg.svh"

module flow_unit (
   input  agen_pkg::agen_in_t op,
   input  agen_pkg::ag_ctrl_t ctrl,
   input  logic               nmi_en,
   input  logic               pf_en,
   input  logic               gp_en,
   output agen_pkg::addr_t    neip,
   output agen_pkg::sel_t     ncs,
   output agen_pkg::addr_t    sp_new,
   output agen_pkg::addr_t    int_addr
);
   import agen_pkg::*;

   addr_t push_step;

   // Next instruction pointer and code segment
   always_comb begin
      if (ctrl.far_jmp) begin
         neip = op.offset[31:0];
      end else if (ctrl.rel_jmp) begin
         neip = op.eip + op.offset[31:0];
      end else begin
         neip = op.eip;
      end
   end

   assign ncs = ctrl.far_jmp ? op.offset[47:32] : op.cs;

   // Size code 0 is not issued by decode and falls back to 32-bit
   always_comb begin
      case (op.mem_size)
         2'd1:    push_step = `AGEN_PUSH_STEP_16;
         2'd3:    push_step = `AGEN_PUSH_STEP_64;
         default: push_step = `AGEN_PUSH_STEP_32;
      endcase
   end

   assign sp_new = ctrl.sp_push ? op.sr2_data - push_step : op.sr2_data;

   // NMI first, then page fault, then general protection
   always_comb begin
      if (nmi_en) begin
         int_addr = `AGEN_NMI_VECTOR;
      end else if (pf_en) begin
         int_addr = `AGEN_PF_VECTOR;
      end else if (gp_en) begin
         int_addr = `AGEN_GP_VECTOR;
      end else begin
         int_addr = '0;
      end
   end

endmodule

/* source/scoreboard_gen.sv */
`timescale 1ns/1ps

module scoreboard_gen (
   input  agen_pkg::reg_id_t  dr1,
   input  agen_pkg::reg_id_t  dr2,
   input  logic               ld_gpr1,
   input  agen_pkg::ag_ctrl_t ctrl,
   output agen_pkg::sb_t      gpr_sb,
   output agen_pkg::sb_t      seg_sb,
   output agen_pkg::sb_t      mm_sb
);
   import agen_pkg::*;

   sb_t dr1_bit;
   sb_t dr2_bit;

   assign dr1_bit = reg_bit(dr1);
   assign dr2_bit = reg_bit(dr2);

   // A push writes both its destination and the stack pointer
   always_comb begin
      gpr_sb = '0;
      if (ld_gpr1) begin
         gpr_sb |= dr1_bit;
      end
      if (ctrl.ld_gpr2) begin
         gpr_sb |= dr2_bit;
      end
   end

   // Segment loads name their target register in dr1
   assign seg_sb = ctrl.ld_seg ? dr1_bit : '0;

   // No MMX writes in this stage
   assign mm_sb = '0;

endmodule

/* test/agen_checker.sv */
`timescale 1ns/1ps

`include "agen_cfg.svh"

module agen_checker (
   input  logic                clk,
   input  logic                rst,
   input  agen_pkg::agen_in_t  in,
   input  logic                in_valid,
   input  logic                stall,
   input  agen_pkg::stage_sb_t ag2_sb,
   input  agen_pkg::stage_sb_t me_sb,
   input  agen_pkg::stage_sb_t me2_sb,
   input  agen_pkg::stage_sb_t ex_sb,
   input  logic                nmi_en,
   input  logic                pf_en,
   input  logic                gp_en,
   input  logic                hold,
   input  agen_pkg::agen_out_t out,
   input  logic                out_valid,
   output int                  error_count,
   output int                  accept_count
);
   import agen_pkg::*;

   agen_out_t exp_out;
   logic      exp_valid;
   logic      exp_stall;
   int        errors = 0;
   int        accepts = 0;

   assign error_count  = errors;
   assign accept_count = accepts;

   function automatic sb_t onehot(input reg_id_t id);
      sb_t m;
      m = '0;
      m[id] = 1'b1;
      return m;
   endfunction

   // Sources the op reads with GPRs in the low byte and segments in the high byte
   function automatic logic [15:0] needed_regs(input agen_in_t op);
      sb_t g;
      sb_t s;
      g = '0;
      s = '0;
      if (op.base_en) begin
         g = g | onehot(op.sr1);
      end
      if (op.sib_en) begin
         g = g | onehot(op.sib_i);
      end
      if (op.kind == OP_PUSH) begin
         g = g | onehot(op.sr2);
         s = s | onehot(op.seg2);
      end
      if ((op.kind == OP_LOAD || op.kind == OP_STORE || op.kind == OP_LOAD_SEG)
          && !op.seg_is_cs) begin
         s = s | onehot(op.seg1);
      end
      return {s, g};
   endfunction

   function automatic logic stage_hit(input logic [15:0] need, input stage_sb_t sb);
      return sb.valid && (((need[7:0] & sb.gpr) != '0) || ((need[15:8] & sb.seg) != '0));
   endfunction

   function automatic agen_out_t expected_result(input agen_in_t op, input logic nmi,
                                                 input logic pf, input logic gp);
      agen_out_t r;
      sel_t      seg;
      r = '0;
      seg = op.seg_is_cs ? op.cs : op.seg1_data;
      r.lin_addr = addr_t'(seg) << 16;
      if (op.base_en) begin
         r.lin_addr = r.lin_addr + op.sr1_data;
      end
      if (op.disp_en) begin
         r.lin_addr = r.lin_addr + op.disp;
      end
      if (op.sib_en) begin
         r.lin_addr = r.lin_addr + (op.sib_i_data << op.scale);
      end
      r.neip   = op.eip;
      r.ncs    = op.cs;
      r.sp_new = op.sr2_data;
      if (op.kind == OP_JMP_REL) begin
         r.neip = op.eip + op.offset[31:0];
      end
      if (op.kind == OP_JMP_FAR) begin
         r.neip = op.offset[31:0];
         r.ncs  = op.offset[47:32];
      end
      if (op.kind == OP_PUSH) begin
         case (op.mem_size)
            2'd1:    r.sp_new = op.sr2_data - 32'd2;
            2'd3:    r.sp_new = op.sr2_data - 32'd8;
            default: r.sp_new = op.sr2_data - 32'd4;
         endcase
         r.gpr_sb = onehot(op.sr2);
      end
      if (op.ld_gpr1) begin
         r.gpr_sb = r.gpr_sb | onehot(op.dr1);
      end
      if (op.kind == OP_LOAD_SEG) begin
         r.seg_sb = onehot(op.dr1);
      end
      if (nmi) begin
         r.int_addr = `AGEN_NMI_VECTOR;
      end else if (pf) begin
         r.int_addr = `AGEN_PF_VECTOR;
      end else if (gp) begin
         r.int_addr = `AGEN_GP_VECTOR;
      end
      return r;
   endfunction

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         $display("[ERROR] %s expected %h actual %h at %0t", name, exp, act, $time);
         errors++;
      end
   endtask

   // Inputs settle on the falling edge, so everything is stable here
   always @(posedge clk) begin
      if (rst) begin
         exp_out   <= '0;
         exp_valid <= 1'b0;
      end else begin
         check_value("out_valid", 32'(exp_valid), 32'(out_valid));
         check_value("out.lin_addr", exp_out.lin_addr, out.lin_addr);
         check_value("out.neip", exp_out.neip, out.neip);
         check_value("out.ncs", 32'(exp_out.ncs), 32'(out.ncs));
         check_value("out.sp_new", exp_out.sp_new, out.sp_new);
         check_value("out.int_addr", exp_out.int_addr, out.int_addr);
         check_value("out.gpr_sb", 32'(exp_out.gpr_sb), 32'(out.gpr_sb));
         check_value("out.seg_sb", 32'(exp_out.seg_sb), 32'(out.seg_sb));
         check_value("out.mm_sb", 32'(exp_out.mm_sb), 32'(out.mm_sb));
         exp_stall = hold || (in_valid && (stage_hit(needed_regs(in), ag2_sb)
                     || stage_hit(needed_regs(in), me_sb) || stage_hit(needed_regs(in), me2_sb)
                     || stage_hit(needed_regs(in), ex_sb)));
         check_value("stall", 32'(exp_stall), 32'(stall));
         if (in_valid && !exp_stall) begin
            exp_out   <= expected_result(in, nmi_en, pf_en, gp_en);
            exp_valid <= 1'b1;
            accepts   <= accepts + 1;
         end else if (!hold) begin
            exp_valid <= 1'b0;
         end
      end
   end

endmodule

/* test/agen_tb.sv */
`timescale 1ns/1ps

module agen_tb;
   import agen_pkg::*;

   localparam int CLK_PERIOD = 100;
   localparam int NUM_OPS    = 400;
   // First ops sweep all addressing modes on loads and stores
   localparam int SWEEP_OPS  = 128;

   logic        clk;
   logic        rst;
   agen_in_t    in;
   logic        in_valid;
   logic        stall;
   stage_sb_t   ag2_sb;
   stage_sb_t   me_sb;
   stage_sb_t   me2_sb;
   stage_sb_t   ex_sb;
   logic        nmi_en;
   logic        pf_en;
   logic        gp_en;
   logic        hold;
   agen_out_t   out;
   logic        out_valid;
   int          check_errors;
   int          accepted;
   int          issued;
   int          tb_errors;
   logic        taken;
   logic [31:0] lfsr_state = 32'h8e3399bb;

   agen_stage dut_i (
      .clk(clk), .rst(rst), .in(in), .in_valid(in_valid), .stall(stall),
      .ag2_sb(ag2_sb), .me_sb(me_sb), .me2_sb(me2_sb), .ex_sb(ex_sb),
      .nmi_en(nmi_en), .pf_en(pf_en), .gp_en(gp_en), .hold(hold),
      .out(out), .out_valid(out_valid)
   );

   agen_checker checker_i (
      .clk(clk), .rst(rst), .in(in), .in_valid(in_valid), .stall(stall),
      .ag2_sb(ag2_sb), .me_sb(me_sb), .me2_sb(me2_sb), .ex_sb(ex_sb),
      .nmi_en(nmi_en), .pf_en(pf_en), .gp_en(gp_en), .hold(hold),
      .out(out), .out_valid(out_valid),
      .error_count(check_errors), .accept_count(accepted)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin : watchdog
      #(NUM_OPS * 20 * CLK_PERIOD);
      $display("Timeout: only %0d of %0d ops issued in time", issued, NUM_OPS);
      $display("Something failed");
      $finish;
   end

   // Galois LFSR for x^32 + x^22 + x^2 + x + 1
   function automatic logic lfsr_bit();
      logic b;
      b = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (b) begin
         lfsr_state = lfsr_state ^ 32'h8020_0003;
      end
      return b;
   endfunction

   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_bit()};
      end
      return v;
   endfunction

   // Sparse pending writes so that stalls come and go
   function automatic stage_sb_t random_scoreboard();
      stage_sb_t s;
      s.valid = lfsr_bit() & lfsr_bit();
      s.gpr   = 8'(random_bits(8)) & 8'(random_bits(8));
      s.seg   = 8'(random_bits(8)) & 8'(random_bits(8));
      s.mm    = 8'(random_bits(8));
      return s;
   endfunction

   function automatic agen_in_t random_op(input int n);
      agen_in_t op;
      op.kind       = op_kind_t'(3'(random_bits(3)));
      op.eip        = random_bits(32);
      op.cs         = 16'(random_bits(16));
      op.offset     = {16'(random_bits(16)), random_bits(32)};
      op.sr1        = reg_id_t'(random_bits(3));
      op.sr2        = reg_id_t'(random_bits(3));
      op.sib_i      = reg_id_t'(random_bits(3));
      op.seg1       = reg_id_t'(random_bits(3));
      op.seg2       = reg_id_t'(random_bits(3));
      {op.sib_en, op.disp_en, op.base_en, op.scale, op.seg_is_cs} = 6'(random_bits(6));
      op.disp       = random_bits(32);
      op.sr1_data   = random_bits(32);
      op.sr2_data   = random_bits(32);
      op.sib_i_data = random_bits(32);
      op.seg1_data  = 16'(random_bits(16));
      op.mem_size   = mem_size_t'(random_bits(2));
      if (op.mem_size == 2'd0) begin
         op.mem_size = 2'd2;
      end
      op.dr1        = reg_id_t'(random_bits(3));
      op.ld_gpr1    = lfsr_bit();
      if (n < SWEEP_OPS) begin
         {op.sib_en, op.disp_en, op.base_en, op.scale, op.seg_is_cs} = 6'(n);
         op.kind = n[6] ? OP_STORE : OP_LOAD;
      end
      return op;
   endfunction

   task automatic drive_side_inputs();
      ag2_sb = random_scoreboard();
      me_sb  = random_scoreboard();
      me2_sb = random_scoreboard();
      ex_sb  = random_scoreboard();
      {nmi_en, pf_en, gp_en} = 3'(random_bits(3));
      hold   = lfsr_bit() & lfsr_bit();
   endtask

   initial begin : stimulus
      rst = 1'b1;
      in = '0;
      in_valid = 1'b0;
      {ag2_sb, me_sb, me2_sb, ex_sb} = '0;
      {nmi_en, pf_en, gp_en, hold} = '0;
      issued = 0;
      tb_errors = 0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      drive_side_inputs();
      while (issued < NUM_OPS) begin
         if (lfsr_bit() & lfsr_bit() & lfsr_bit()) begin
            in_valid = 1'b0;
            @(negedge clk);
            drive_side_inputs();
         end else begin
            in = random_op(issued);
            in_valid = 1'b1;
            taken = 1'b0;
            // Op stays on the bus until the stage takes it
            while (!taken) begin
               @(posedge clk);
               taken = !stall;
               @(negedge clk);
               drive_side_inputs();
            end
            issued++;
         end
      end
      in_valid = 1'b0;
      hold = 1'b0;
      repeat (3) @(negedge clk);
      if (accepted != issued) begin
         $display("Op count mismatch: %0d issued but %0d accepted", issued, accepted);
         tb_errors++;
      end
      $display("Errors: %0d from checker, %0d from op count", check_errors, tb_errors);
      if (check_errors == 0 && tb_errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule
